// File: logic/wr_pattern_defs.svh
// widths and constants shared by the write-data pattern generator
`ifndef WR_PATTERN_DEFS_SVH
`define WR_PATTERN_DEFS_SVH

// write-data bus
`define WDATA_WIDTH       1024
`define STRB_WIDTH        128

// one pattern word per lane
`define LANE_WIDTH        32
`define LANE_STRB_WIDTH   4
`define LANE_COUNT        32

// control fields and counters
`define SIZE_CODE_WIDTH   3
`define BURST_LEN_WIDTH   8
`define BEAT_COUNT_WIDTH  40
`define WRAP_LEN_WIDTH    4
`define SLOT_WIDTH        5
`define LANE_CNT_WIDTH    6
`define STATE_WIDTH       4

// lowest base bit that holds its value in wrap mode at wrap_len 0
`define WRAP_BASE_BIT     10

`endif

// File: logic/axi_wdata_pkg.sv
// types of the AXI write-data bus as seen by the pattern generator
`include "wr_pattern_defs.svh"

package axi_wdata_pkg;

    // one 32-bit pattern word and its byte enables
    typedef logic [`LANE_WIDTH-1:0] lane_word_t;
    typedef logic [`LANE_STRB_WIDTH-1:0] lane_strb_t;

    // AXI transfer size, codes 0 and 1 are treated as 128 bytes
    typedef enum logic [`SIZE_CODE_WIDTH-1:0]
    {
        SIZE_4B   = 3'd2,
        SIZE_8B   = 3'd3,
        SIZE_16B  = 3'd4,
        SIZE_32B  = 3'd5,
        SIZE_64B  = 3'd6,
        SIZE_128B = 3'd7
    } size_code_t;

    // beats per burst minus one
    typedef logic [`BURST_LEN_WIDTH-1:0] burst_len_t;

endpackage

// File: logic/pattern_ctrl_pkg.sv
// types of the pattern generator control path
`include "wr_pattern_defs.svh"

package pattern_ctrl_pkg;

    // one-hot sequencer states
    typedef enum logic [`STATE_WIDTH-1:0]
    {
        IDLE = 4'b0001,
        LOAD = 4'b0010,
        SEND = 4'b0100,
        DONE = 4'b1000
    } seq_state_t;

    typedef logic [`BEAT_COUNT_WIDTH-1:0] beat_count_t;

    // number of extra base bits that advance in wrap mode
    typedef logic [`WRAP_LEN_WIDTH-1:0] wrap_len_t;

    // position of a narrow beat inside the bus
    typedef logic [`SLOT_WIDTH-1:0] slot_index_t;

    // words per beat, always a power of two up to 32
    typedef logic [`LANE_CNT_WIDTH-1:0] lane_count_t;

endpackage

// File: logic/burst_sequencer.sv
// sequencer of the write-data pattern generator
// runs the transfer FSM and keeps beat, burst and slot counters and the word base
`include "wr_pattern_defs.svh"

module burst_sequencer
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          wr_engine_start,
    input  pattern_ctrl_pkg::beat_count_t total_wr_beat_count,
    input  logic                          wrap_mode,
    input  pattern_ctrl_pkg::wrap_len_t   wrap_len,
    input  axi_wdata_pkg::size_code_t     wr_size,
    input  axi_wdata_pkg::burst_len_t     wr_len,
    input  axi_wdata_pkg::lane_word_t     wr_init_data,
    input  logic                          beat_take,
    output logic                          beat_pending,
    output logic                          burst_end,
    output axi_wdata_pkg::lane_word_t     pattern_base,
    output pattern_ctrl_pkg::slot_index_t slot,
    output pattern_ctrl_pkg::lane_count_t lane_count
);

    import axi_wdata_pkg::*;
    import pattern_ctrl_pkg::*;

    seq_state_t  state;
    seq_state_t  state_next;
    beat_count_t beat_cnt;
    burst_len_t  burst_cnt;
    lane_count_t size_words;
    lane_word_t  base_incr;
    lane_word_t  wrap_low_mask;
    lane_word_t  base_next;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        case (state)
            IDLE:
                if (wr_engine_start)
                    state_next = LOAD;
                else
                    state_next = IDLE;
            LOAD:
                state_next = SEND;
            SEND:
                if (beat_cnt == '0)
                    state_next = DONE;
                else
                    state_next = SEND;
            DONE:
                state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    // words carried by one beat
    always_comb
    begin
        case (wr_size)
            SIZE_4B:   size_words = 6'd1;
            SIZE_8B:   size_words = 6'd2;
            SIZE_16B:  size_words = 6'd4;
            SIZE_32B:  size_words = 6'd8;
            SIZE_64B:  size_words = 6'd16;
            default:   size_words = 6'd32;
        endcase
    end

    assign beat_pending = (state == SEND) && (beat_cnt != '0);
    assign burst_end    = (burst_cnt == '0);

    // in wrap mode only the bits below WRAP_BASE_BIT+wrap_len advance
    assign base_incr     = pattern_base + lane_word_t'(lane_count);
    assign wrap_low_mask = (lane_word_t'(1) << (`WRAP_BASE_BIT + int'(wrap_len)))
                           - lane_word_t'(1);
    assign base_next     = wrap_mode ? ((pattern_base & ~wrap_low_mask) |
                                        (base_incr & wrap_low_mask))
                                     : base_incr;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            lane_count   <= '0;
            pattern_base <= '0;
            beat_cnt     <= '0;
        end
        else if (state == LOAD)
        begin
            lane_count   <= size_words;
            pattern_base <= wr_init_data;
            beat_cnt     <= total_wr_beat_count;
        end
        else if (beat_take)
        begin
            pattern_base <= base_next;
            beat_cnt     <= beat_cnt - 1'b1;
        end
    end

    // burst counter reloads after the last beat of each burst
    always_ff @(posedge clk)
    begin
        if (!resetn)
            burst_cnt <= '0;
        else if (state == LOAD)
            burst_cnt <= wr_len;
        else if (beat_take && burst_end)
            burst_cnt <= wr_len;
        else if (beat_take)
            burst_cnt <= burst_cnt - 1'b1;
    end

    // narrow beats walk upward through the bus and restart with every burst
    always_ff @(posedge clk)
    begin
        if (!resetn)
            slot <= '0;
        else if (state == LOAD)
            slot <= '0;
        else if (beat_take && burst_end)
            slot <= '0;
        else if (beat_take)
            slot <= slot + 1'b1;
    end

endmodule

// File: logic/lane_generator.sv
// one 32-bit lane of the write-data bus
// decides whether it belongs to the current slot and registers its word and strobe
module lane_generator
#(
    parameter int LANE = 0
)
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          beat_take,
    input  axi_wdata_pkg::lane_word_t     pattern_base,
    input  pattern_ctrl_pkg::slot_index_t slot,
    input  pattern_ctrl_pkg::lane_count_t lane_count,
    output axi_wdata_pkg::lane_word_t     lane_data,
    output axi_wdata_pkg::lane_strb_t     lane_strb
);

    import axi_wdata_pkg::*;
    import pattern_ctrl_pkg::*;

    localparam slot_index_t lane_pos = slot_index_t'(LANE);

    lane_count_t       word_mask;
    logic [10:0]       slot_prod;
    slot_index_t       slot_first;
    slot_index_t       word_offset;
    logic              lane_active;

    // lane_count is a power of two so the mask gives position modulo lane_count
    assign word_mask   = lane_count - 1'b1;
    assign word_offset = lane_pos & word_mask[4:0];

    // first lane of the active slot, taken modulo the bus width
    assign slot_prod   = slot * lane_count;
    assign slot_first  = slot_prod[4:0];
    assign lane_active = ((lane_pos & ~word_mask[4:0]) == slot_first);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            lane_data <= '0;
            lane_strb <= '0;
        end
        else if (beat_take)
        begin
            if (lane_active)
            begin
                lane_data <= pattern_base + lane_word_t'(word_offset);
                lane_strb <= '1;
            end
            else
            begin
                lane_data <= '0;
                lane_strb <= '0;
            end
        end
    end

endmodule

// File: logic/beat_output.sv
// output stage of the write-data channel
// holds wvalid and wlast and takes a new beat when the register is free
module beat_output
(
    input  logic clk,
    input  logic resetn,
    input  logic beat_pending,
    input  logic burst_end,
    input  logic m_axi_wready,
    output logic beat_take,
    output logic m_axi_wvalid,
    output logic m_axi_wlast
);

    logic out_free;

    // register is empty or its beat leaves this cycle
    assign out_free  = !m_axi_wvalid || m_axi_wready;
    assign beat_take = beat_pending && out_free;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            m_axi_wvalid <= 1'b0;
        else if (beat_take)
            m_axi_wvalid <= 1'b1;
        else if (m_axi_wready)
            m_axi_wvalid <= 1'b0;
    end

    // wlast holds with the beat under back-pressure
    always_ff @(posedge clk)
    begin
        if (!resetn)
            m_axi_wlast <= 1'b0;
        else if (beat_take)
            m_axi_wlast <= burst_end;
    end

endmodule

// File: logic/wr_data_send_channel.sv
// AXI write-data pattern generator
// sends ascending 32-bit words from a seed in bursts of wr_len+1 beats
`include "wr_pattern_defs.svh"

module wr_data_send_channel
(
    input  logic                          clk,
    input  logic                          resetn,
    output logic [`WDATA_WIDTH-1:0]       m_axi_wdata,
    output logic [`STRB_WIDTH-1:0]        m_axi_wstrb,
    output logic                          m_axi_wvalid,
    output logic                          m_axi_wlast,
    input  logic                          m_axi_wready,
    input  pattern_ctrl_pkg::beat_count_t total_wr_beat_count,
    input  logic                          wr_engine_start,
    input  logic                          wrap_mode,
    input  pattern_ctrl_pkg::wrap_len_t   wrap_len,
    input  axi_wdata_pkg::size_code_t     wr_size,
    input  axi_wdata_pkg::burst_len_t     wr_len,
    input  axi_wdata_pkg::lane_word_t     wr_init_data
);

    import axi_wdata_pkg::*;
    import pattern_ctrl_pkg::*;

    logic        beat_pending;
    logic        burst_end;
    logic        beat_take;
    lane_word_t  pattern_base;
    slot_index_t slot;
    lane_count_t lane_count;

    burst_sequencer u_sequencer
    (
        .clk                 (clk),
        .resetn              (resetn),
        .wr_engine_start     (wr_engine_start),
        .total_wr_beat_count (total_wr_beat_count),
        .wrap_mode           (wrap_mode),
        .wrap_len            (wrap_len),
        .wr_size             (wr_size),
        .wr_len              (wr_len),
        .wr_init_data        (wr_init_data),
        .beat_take           (beat_take),
        .beat_pending        (beat_pending),
        .burst_end           (burst_end),
        .pattern_base        (pattern_base),
        .slot                (slot),
        .lane_count          (lane_count)
    );

    // lane k owns data bits 32k and up and strobe bits 4k and up
    for (genvar k = 0; k < `LANE_COUNT; k++)
    begin : g_lane
        lane_generator #(.LANE(k)) u_lane
        (
            .clk          (clk),
            .resetn       (resetn),
            .beat_take    (beat_take),
            .pattern_base (pattern_base),
            .slot         (slot),
            .lane_count   (lane_count),
            .lane_data    (m_axi_wdata[k*`LANE_WIDTH +: `LANE_WIDTH]),
            .lane_strb    (m_axi_wstrb[k*`LANE_STRB_WIDTH +: `LANE_STRB_WIDTH])
        );
    end

    beat_output u_output
    (
        .clk          (clk),
        .resetn       (resetn),
        .beat_pending (beat_pending),
        .burst_end    (burst_end),
        .m_axi_wready (m_axi_wready),
        .beat_take    (beat_take),
        .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wlast  (m_axi_wlast)
    );

endmodule

// File: tests/tb_checks.svh
// compare tasks, transfer driver and directed tests of the pattern generator testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_word(input lane_word_t got, input lane_word_t exp, input string what);
    if (got !== exp)
    begin
        data_errors++;
        $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_strb(input lane_strb_t got, input lane_strb_t exp, input string what);
    if (got !== exp)
    begin
        strb_errors++;
        $display("FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
        last_errors++;
        $display("FAILED at time %0t: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

// starts one transfer and follows it until every beat is accepted
task automatic run_transfer(input size_code_t size, input burst_len_t len, input int count,
                            input lane_word_t seed_word, input logic wrap,
                            input wrap_len_t wl, input logic random_ready,
                            output int first_valid);
    int                      words;
    int                      beat;
    int                      edges;
    int                      rnd;
    int                      keep_from;
    int                      i;
    logic                    held;
    logic [`WDATA_WIDTH-1:0] held_data;
    logic                    held_last;
    lane_word_t              base;
    lane_word_t              keep_mask;
    words     = words_for_size(size);
    base      = seed_word;
    keep_from = `WRAP_BASE_BIT + int'(wl);
    // bits that never move in wrap mode
    for (i = 0; i < `LANE_WIDTH; i++)
        keep_mask[i] = wrap && (i >= keep_from);
    beat        = 0;
    edges       = -1;
    held        = 1'b0;
    first_valid = -1;
    @(posedge clk);
    wr_size             <= size;
    wr_len              <= len;
    total_wr_beat_count <= beat_count_t'(count);
    wr_init_data        <= seed_word;
    wrap_mode           <= wrap;
    wrap_len            <= wl;
    wr_engine_start     <= 1'b1;
    while (beat < count && edges < count * 8 + 20)
    begin
        @(posedge clk);
        edges++;
        rnd = $random(rand_seed);
        wr_engine_start <= 1'b0;
        m_axi_wready    <= random_ready ? rnd[0] : 1'b1;
        @(negedge clk);
        if (held)
        begin
            check_last(m_axi_wvalid, 1'b1, "wvalid under back-pressure");
            check_last(m_axi_wlast, held_last, "wlast under back-pressure");
            if (m_axi_wdata !== held_data)
            begin
                data_errors++;
                $display("FAILED at time %0t: wdata changed under back-pressure", $time);
            end
        end
        if (m_axi_wvalid && first_valid < 0)
            first_valid = edges;
        held      = m_axi_wvalid && !m_axi_wready;
        held_data = m_axi_wdata;
        held_last = m_axi_wlast;
        if (m_axi_wvalid && m_axi_wready)
        begin
            check_beat(beat, words, int'(len), base, seed_word, keep_mask);
            base = next_base(base, words, wrap, wl);
            beat++;
        end
    end
    if (beat < count)
    begin
        other_errors++;
        $display("transfer stopped after %0d of %0d beats, no more beats were offered",
                 beat, count);
    end
    // channel stays quiet once the programmed beats are out
    repeat (6)
    begin
        @(posedge clk);
        wr_engine_start <= 1'b0;
        m_axi_wready    <= 1'b1;
        @(negedge clk);
        check_last(m_axi_wvalid, 1'b0, "wvalid with no beats left");
    end
endtask

task automatic test_reset_and_empty();
    int first_valid;
    int k;
    check_last(m_axi_wvalid, 1'b0, "wvalid after reset");
    check_last(m_axi_wlast, 1'b0, "wlast after reset");
    for (k = 0; k < `LANE_COUNT; k++)
    begin
        check_word(m_axi_wdata[k*`LANE_WIDTH +: `LANE_WIDTH], '0, "data after reset");
        check_strb(m_axi_wstrb[k*`LANE_STRB_WIDTH +: `LANE_STRB_WIDTH], '0,
                   "strobe after reset");
    end
    run_transfer(SIZE_128B, 8'd0, 0, 32'h0000_0000, 1'b0, 4'd0, 1'b0, first_valid);
endtask

task automatic test_full_width();
    int first_valid;
    run_transfer(SIZE_128B, 8'd3, 8, 32'h1000_0000, 1'b0, 4'd0, 1'b0, first_valid);
    if (first_valid != 2)
    begin
        other_errors++;
        $display("FAILED at time %0t: first wvalid %0d cycles after start, expected 2",
                 $time, first_valid);
    end
endtask

task automatic test_narrow_walk();
    int first_valid;
    run_transfer(SIZE_4B, 8'd4, 12, 32'hcafe_0100, 1'b0, 4'd0, 1'b0, first_valid);
endtask

// low 10 bits of the seed start at 1012 so the base rolls over within the transfer
task automatic test_wrap_base();
    int first_valid;
    run_transfer(SIZE_16B, 8'd7, 16, 32'h5a5a_53f4, 1'b1, 4'd0, 1'b0, first_valid);
endtask

task automatic test_random_ready();
    int first_valid;
    run_transfer(SIZE_32B, 8'd5, 24, 32'h0123_4560, 1'b0, 4'd0, 1'b1, first_valid);
endtask

`endif

// File: tests/tb_wr_data_send_channel.sv
// testbench of the AXI write-data pattern generator
// runs directed transfers and checks each accepted beat against a reference model
`include "wr_pattern_defs.svh"

module tb_wr_data_send_channel;

    import axi_wdata_pkg::*;
    import pattern_ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    // 60 beats are programmed over all tests
    localparam int WATCHDOG_CYCLES = 60 * 200 + 500;

    logic                    clk;
    logic                    resetn;
    logic                    m_axi_wready;
    beat_count_t             total_wr_beat_count;
    logic                    wr_engine_start;
    logic                    wrap_mode;
    wrap_len_t               wrap_len;
    size_code_t              wr_size;
    burst_len_t              wr_len;
    lane_word_t              wr_init_data;
    logic [`WDATA_WIDTH-1:0] m_axi_wdata;
    logic [`STRB_WIDTH-1:0]  m_axi_wstrb;
    logic                    m_axi_wvalid;
    logic                    m_axi_wlast;

    int     data_errors;
    int     strb_errors;
    int     last_errors;
    int     other_errors;
    integer rand_seed;

    wr_data_send_channel DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // size codes 2 to 6 double the words per beat and all others fill the bus
    function automatic int words_for_size(input size_code_t size);
        int code;
        code = int'(size);
        if (code >= 2 && code <= 6)
            return 1 << (code - 2);
        return `LANE_COUNT;
    endfunction

    // wrap mode keeps every base bit from WRAP_BASE_BIT+wrap_len upward
    function automatic lane_word_t next_base(input lane_word_t base, input int words,
                                             input logic wrap, input wrap_len_t wl);
        lane_word_t sum;
        lane_word_t result;
        int         keep_from;
        int         i;
        sum       = base + lane_word_t'(words);
        keep_from = wrap ? `WRAP_BASE_BIT + int'(wl) : `LANE_WIDTH;
        for (i = 0; i < `LANE_WIDTH; i++)
            result[i] = (i < keep_from) ? sum[i] : base[i];
        return result;
    endfunction

    // one accepted beat against the model with the slot taken modulo the slots on the bus
    task automatic check_beat(input int beat, input int words, input int len,
                              input lane_word_t base, input lane_word_t seed_word,
                              input lane_word_t keep_mask);
        int         slot;
        int         k;
        logic       active;
        lane_word_t exp_word;
        lane_word_t got_word;
        slot = (beat % (len + 1)) % (`LANE_COUNT / words);
        for (k = 0; k < `LANE_COUNT; k++)
        begin
            active   = (k / words) == slot;
            exp_word = active ? base + lane_word_t'(k % words) : '0;
            got_word = m_axi_wdata[k*`LANE_WIDTH +: `LANE_WIDTH];
            check_word(got_word, exp_word, $sformatf("beat %0d lane %0d data", beat, k));
            check_strb(m_axi_wstrb[k*`LANE_STRB_WIDTH +: `LANE_STRB_WIDTH],
                       lane_strb_t'({`LANE_STRB_WIDTH{active}}),
                       $sformatf("beat %0d lane %0d strobe", beat, k));
            if (active && keep_mask != '0)
                check_word(got_word & keep_mask, seed_word & keep_mask,
                           $sformatf("beat %0d lane %0d fixed upper bits", beat, k));
        end
        check_last(m_axi_wlast, (beat % (len + 1)) == len, $sformatf("beat %0d wlast", beat));
    endtask

    `include "tb_checks.svh"

    initial
    begin
        data_errors         = 0;
        strb_errors         = 0;
        last_errors         = 0;
        other_errors        = 0;
        rand_seed           = 92753;
        resetn              <= 1'b0;
        m_axi_wready        <= 1'b1;
        wr_engine_start     <= 1'b0;
        total_wr_beat_count <= '0;
        wrap_mode           <= 1'b0;
        wrap_len            <= '0;
        wr_size             <= SIZE_128B;
        wr_len              <= '0;
        wr_init_data        <= '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        test_reset_and_empty();
        test_full_width();
        test_narrow_walk();
        test_wrap_base();
        test_random_ready();
        $display("errors: data %0d, strobe %0d, flags %0d, other %0d",
                 data_errors, strb_errors, last_errors, other_errors);
        if (data_errors + strb_errors + last_errors + other_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
+incdir+tests
logic/axi_wdata_pkg.sv
logic/pattern_ctrl_pkg.sv
logic/burst_sequencer.sv
logic/lane_generator.sv
logic/beat_output.sv
logic/wr_data_send_channel.sv
tests/tb_wr_data_send_channel.sv

// File: Makefile
# Verilator simulation of the write-data pattern generator

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_wr_data_send_channel
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation reported a failure"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
